//--- rtl/exec_pkg.sv
package exec_pkg;

    // data path sizes
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;
    localparam int REG_AW   = $clog2(NUM_REGS);
    localparam int SHAMT_W  = $clog2(XLEN);

    // major opcodes
    localparam logic [5:0] OP_LWI     = 6'b000010;
    localparam logic [5:0] OP_SWI     = 6'b001010;
    localparam logic [5:0] OP_TY_LS   = 6'b011100;
    localparam logic [5:0] OP_TY_BASE = 6'b100000;
    localparam logic [5:0] OP_MOVI    = 6'b100010;
    localparam logic [5:0] OP_JJ      = 6'b100100;
    localparam logic [5:0] OP_TY_B    = 6'b100110;
    localparam logic [5:0] OP_ADDI    = 6'b101000;
    localparam logic [5:0] OP_XORI    = 6'b101011;
    localparam logic [5:0] OP_ORI     = 6'b101100;

    // base type sub-ops
    localparam logic [4:0] SUB_ADD   = 5'b00000;
    localparam logic [4:0] SUB_SUB   = 5'b00001;
    localparam logic [4:0] SUB_AND   = 5'b00010;
    localparam logic [4:0] SUB_XOR   = 5'b00011;
    localparam logic [4:0] SUB_OR    = 5'b00100;
    localparam logic [4:0] SUB_SLLI  = 5'b01000;
    localparam logic [4:0] SUB_SRLI  = 5'b01001;
    localparam logic [4:0] SUB_ROTRI = 5'b01011;

    // load/store type sub-ops
    localparam logic [7:0] LS_LW = 8'b00000010;
    localparam logic [7:0] LS_SW = 8'b00001010;

    // register form of the word
    typedef struct packed {
        logic              spare;
        logic [5:0]        opcode;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] ra;
        logic [REG_AW-1:0] rb;
        logic [4:0]        pad;
        logic [4:0]        sub_op;
    } instr_reg_t;

    // immediate form of the word
    typedef struct packed {
        logic              spare;
        logic [5:0]        opcode;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] ra;
        logic [14:0]       imm15;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t rform;
        instr_imm_t iform;
    } instr_u;

    // decoded request into the ALU
    typedef struct packed {
        logic [5:0]      opcode;
        logic [4:0]      sub_op_base;
        logic [7:0]      sub_op_ls;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
    } alu_req_t;

    typedef struct packed {
        logic [XLEN-1:0] result;
        logic            overflow;
        logic            zero;
    } alu_resp_t;

    // write-back into the register file
    typedef struct packed {
        logic              en;
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   data;
    } wb_t;

endpackage

//--- rtl/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder
    import exec_pkg::*;
(
    input  instr_u            instr,
    output logic [REG_AW-1:0] ra_addr,
    output logic [REG_AW-1:0] rb_addr,
    input  logic [XLEN-1:0]   ra_data,
    input  logic [XLEN-1:0]   rb_data,
    output alu_req_t          req,
    output logic              wb_en_dec,
    output logic [REG_AW-1:0] rt
);

    logic [XLEN-1:0] imm15_sext;
    logic [XLEN-1:0] imm15_zext;
    logic [XLEN-1:0] imm20_sext;
    logic [XLEN-1:0] shamt_zext;
    logic            base_known;
    logic            base_shift;

    // register fields go straight to the register file
    assign ra_addr = instr.rform.ra;
    assign rb_addr = instr.rform.rb;
    assign rt      = instr.rform.rt;

    assign imm15_sext = {{(XLEN-15){instr.iform.imm15[14]}}, instr.iform.imm15};
    assign imm15_zext = {{(XLEN-15){1'b0}}, instr.iform.imm15};

    // movi takes ra and imm15 together as a 20-bit immediate
    assign imm20_sext = {{(XLEN-20){instr.iform.ra[REG_AW-1]}},
                         instr.iform.ra,
                         instr.iform.imm15};

    // rb field used as shift amount
    assign shamt_zext = {{(XLEN-REG_AW){1'b0}}, instr.rform.rb};

    assign base_known = instr.rform.sub_op inside {SUB_ADD, SUB_SUB, SUB_AND, SUB_OR,
                                                   SUB_XOR, SUB_SLLI, SUB_SRLI, SUB_ROTRI};
    assign base_shift = instr.rform.sub_op inside {SUB_SLLI, SUB_SRLI, SUB_ROTRI};

    always_comb
    begin
        req.opcode      = instr.rform.opcode;
        req.sub_op_base = instr.rform.sub_op;
        req.sub_op_ls   = {instr.rform.pad[2:0], instr.rform.sub_op};
        req.src1        = ra_data;
        req.src2        = rb_data;
        wb_en_dec       = 1'b0;

        case (instr.rform.opcode)
            OP_TY_BASE:
            begin
                if (base_shift)
                begin
                    req.src2 = shamt_zext;
                end
                wb_en_dec = base_known;
            end
            OP_ADDI:
            begin
                req.src2  = imm15_sext;
                wb_en_dec = 1'b1;
            end
            OP_ORI, OP_XORI:
            begin
                req.src2  = imm15_zext;
                wb_en_dec = 1'b1;
            end
            OP_MOVI:
            begin
                req.src1  = imm20_sext;
                req.src2  = '0;
                wb_en_dec = 1'b1;
            end
            OP_LWI, OP_SWI:
            begin
                // word offset
                req.src2 = imm15_sext << 2;
            end
            default:
            begin
                // ls, branch and jj keep register operands and never write
                wb_en_dec = 1'b0;
            end
        endcase
    end

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/100ps

module reg_file
    import exec_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [REG_AW-1:0] ra_addr,
    input  logic [REG_AW-1:0] rb_addr,
    output logic [XLEN-1:0]   ra_data,
    output logic [XLEN-1:0]   rb_data,
    input  wb_t               wb
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // asynchronous read ports
    assign ra_data = regs[ra_addr];
    assign rb_data = regs[rb_addr];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb.en)
        begin
            regs[wb.addr] <= wb.data;
        end
    end

    // write-back from the ALU must carry a clean target
    property p_wb_addr_known;
        @(posedge clk) disable iff (reset)
            wb.en |-> !$isunknown(wb.addr);
    endproperty

    a_wb_addr_known: assert property (p_wb_addr_known)
        else $error("reg_file: write enabled with unknown address");

endmodule

//--- rtl/alu.sv
`timescale 1ns/100ps

module alu
    import exec_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              enable_execute,
    input  alu_req_t          req,
    input  logic              wb_en_dec,
    input  logic [REG_AW-1:0] rt,
    output alu_resp_t         resp,
    output logic              result_valid,
    output wb_t               wb
);

    logic [XLEN-1:0]    next_result;
    logic               next_overflow;
    logic               next_zero;
    logic [XLEN:0]      sum;
    logic [XLEN:0]      diff;
    logic [2*XLEN-1:0]  rotate;
    logic [SHAMT_W-1:0] shamt;
    logic               arith_op;

    // split at bit 31 so overflow is carry(30) ^ carry(31)
    function automatic logic [XLEN:0] add_split(
        input logic [XLEN-1:0] x,
        input logic [XLEN-1:0] y,
        input logic            sub
    );
        logic            c_low;
        logic            c_top;
        logic [XLEN-1:0] r;
        if (sub)
        begin
            {c_low, r[XLEN-2:0]} = {1'b0, x[XLEN-2:0]} - {1'b0, y[XLEN-2:0]};
            {c_top, r[XLEN-1]}   = {1'b0, x[XLEN-1]} - {1'b0, y[XLEN-1]} - {1'b0, c_low};
        end
        else
        begin
            {c_low, r[XLEN-2:0]} = {1'b0, x[XLEN-2:0]} + {1'b0, y[XLEN-2:0]};
            {c_top, r[XLEN-1]}   = {1'b0, x[XLEN-1]} + {1'b0, y[XLEN-1]} + {1'b0, c_low};
        end
        return {c_low ^ c_top, r};
    endfunction

    assign shamt  = req.src2[SHAMT_W-1:0];
    assign sum    = add_split(req.src1, req.src2, 1'b0);
    assign diff   = add_split(req.src1, req.src2, 1'b1);
    assign rotate = {req.src1, req.src1} >> shamt;

    always_comb
    begin
        next_result   = '0;
        next_overflow = 1'b0;
        case (req.opcode)
            OP_TY_BASE:
            begin
                case (req.sub_op_base)
                    SUB_ADD:   {next_overflow, next_result} = sum;
                    SUB_SUB:   {next_overflow, next_result} = diff;
                    SUB_AND:   next_result = req.src1 & req.src2;
                    SUB_OR:    next_result = req.src1 | req.src2;
                    SUB_XOR:   next_result = req.src1 ^ req.src2;
                    SUB_SRLI:  next_result = req.src1 >> shamt;
                    SUB_SLLI:  next_result = req.src1 << shamt;
                    SUB_ROTRI: next_result = rotate[XLEN-1:0];
                    default:   next_result = '0;
                endcase
            end
            OP_ADDI, OP_LWI, OP_SWI: {next_overflow, next_result} = sum;
            OP_ORI:  next_result = req.src1 | req.src2;
            OP_XORI: next_result = req.src1 ^ req.src2;
            OP_MOVI: next_result = req.src1;
            OP_TY_LS:
            begin
                // address only
                if (req.sub_op_ls inside {LS_LW, LS_SW})
                begin
                    {next_overflow, next_result} = sum;
                end
            end
            // zero means equal
            OP_TY_B: next_result = req.src1 ^ req.src2;
            default: next_result = '0;
        endcase
    end

    assign next_zero = (next_result == '0);

    // result goes back the same edge it is registered
    assign wb.en   = enable_execute & wb_en_dec;
    assign wb.addr = rt;
    assign wb.data = next_result;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            resp         <= '0;
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= enable_execute;
            if (enable_execute)
            begin
                resp.result   <= next_result;
                resp.overflow <= next_overflow;
                resp.zero     <= next_zero;
            end
        end
    end

    assign arith_op = ((req.opcode == OP_TY_BASE) &&
                       (req.sub_op_base inside {SUB_ADD, SUB_SUB})) ||
                      (req.opcode inside {OP_ADDI, OP_LWI, OP_SWI}) ||
                      ((req.opcode == OP_TY_LS) && (req.sub_op_ls inside {LS_LW, LS_SW}));

    property p_ovf_arith_only;
        @(posedge clk) disable iff (reset)
            (result_valid && resp.overflow) |-> $past(arith_op);
    endproperty

    property p_no_valid_after_idle;
        @(posedge clk) disable iff (reset)
            !enable_execute |=> !result_valid;
    endproperty

    a_ovf_arith_only: assert property (p_ovf_arith_only)
        else $error("alu: overflow on a non add/sub operation");

    a_no_valid_after_idle: assert property (p_no_valid_after_idle)
        else $error("alu: result_valid without a preceding strobe");

endmodule

//--- rtl/exec_unit.sv
`timescale 1ns/100ps

module exec_unit
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      instr_valid,
    input  instr_u    instr,
    output logic      result_valid,
    output alu_resp_t resp
);

    logic [REG_AW-1:0] ra_addr;
    logic [REG_AW-1:0] rb_addr;
    logic [XLEN-1:0]   ra_data;
    logic [XLEN-1:0]   rb_data;
    alu_req_t          req;
    logic              wb_en_dec;
    logic [REG_AW-1:0] rt;
    wb_t               wb;

    // decode and operand select
    instr_decoder u_decoder (
        .instr     (instr),
        .ra_addr   (ra_addr),
        .rb_addr   (rb_addr),
        .ra_data   (ra_data),
        .rb_data   (rb_data),
        .req       (req),
        .wb_en_dec (wb_en_dec),
        .rt        (rt)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .ra_addr (ra_addr),
        .rb_addr (rb_addr),
        .ra_data (ra_data),
        .rb_data (rb_data),
        .wb      (wb)
    );

    // write-back lands at the sampling edge
    alu u_alu (
        .clk            (clk),
        .reset          (reset),
        .enable_execute (instr_valid),
        .req            (req),
        .wb_en_dec      (wb_en_dec),
        .rt             (rt),
        .resp           (resp),
        .result_valid   (result_valid),
        .wb             (wb)
    );

endmodule

//--- verif/exec_ref.svh
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// operand select and write-back decision for one word
function automatic void ref_operands(
    input  logic [31:0] word,
    input  logic [31:0] va,
    input  logic [31:0] vb,
    output logic [31:0] s1,
    output logic [31:0] s2,
    output logic        wr
);
    s1 = va;
    s2 = vb;
    wr = 1'b0;
    case (word[30:25])
        OP_TY_BASE:
        begin
            if (word[4:0] inside {SUB_SLLI, SUB_SRLI, SUB_ROTRI})
            begin
                s2 = {27'd0, word[14:10]};
            end
            wr = word[4:0] inside {SUB_ADD, SUB_SUB, SUB_AND, SUB_OR, SUB_XOR,
                                   SUB_SLLI, SUB_SRLI, SUB_ROTRI};
        end
        OP_ADDI:
        begin
            s2 = {{17{word[14]}}, word[14:0]};
            wr = 1'b1;
        end
        OP_ORI, OP_XORI:
        begin
            s2 = {17'd0, word[14:0]};
            wr = 1'b1;
        end
        OP_MOVI:
        begin
            s1 = {{12{word[19]}}, word[19:0]};
            s2 = '0;
            wr = 1'b1;
        end
        OP_LWI, OP_SWI: s2 = {{15{word[14]}}, word[14:0], 2'b00};
        default: wr = 1'b0;
    endcase
endfunction

// returns {overflow, result}
function automatic logic [32:0] ref_alu(
    input logic [31:0] word,
    input logic [31:0] s1,
    input logic [31:0] s2
);
    logic [31:0] r;
    logic        is_add;
    logic        is_sub;
    logic        ovf;
    r      = '0;
    is_add = 1'b0;
    is_sub = 1'b0;
    case (word[30:25])
        OP_TY_BASE:
        begin
            case (word[4:0])
                SUB_ADD:   is_add = 1'b1;
                SUB_SUB:   is_sub = 1'b1;
                SUB_AND:   r = s1 & s2;
                SUB_OR:    r = s1 | s2;
                SUB_XOR:   r = s1 ^ s2;
                SUB_SLLI:  r = s1 << s2[4:0];
                SUB_SRLI:  r = s1 >> s2[4:0];
                SUB_ROTRI: r = (s1 >> s2[4:0]) | (s1 << (6'd32 - s2[4:0]));
                default:   r = '0;
            endcase
        end
        OP_ADDI, OP_LWI, OP_SWI: is_add = 1'b1;
        OP_ORI:            r = s1 | s2;
        OP_XORI, OP_TY_B:  r = s1 ^ s2;
        OP_MOVI:           r = s1;
        OP_TY_LS:          is_add = (word[7:0] == LS_LW) || (word[7:0] == LS_SW);
        default:           r = '0;
    endcase
    if (is_add)
    begin
        r = s1 + s2;
    end
    if (is_sub)
    begin
        r = s1 - s2;
    end
    // signed overflow from the operand and result sign bits
    ovf = (is_add && (s1[31] == s2[31]) && (r[31] != s1[31])) ||
          (is_sub && (s1[31] != s2[31]) && (r[31] != s1[31]));
    return {ovf, r};
endfunction

`endif

//--- verif/tb_exec_unit.sv
`timescale 1ns/100ps

module tb_exec_unit
    import exec_pkg::*;
();

    logic            clk;
    logic            reset;
    logic            instr_valid;
    instr_u          instr;
    logic            result_valid;
    alu_resp_t       resp;
    logic [XLEN-1:0] shadow [NUM_REGS];
    alu_resp_t       expected_q [$];
    alu_resp_t       want;
    logic            strobe_d;
    logic [31:0]     rnd;
    integer          seed;
    int              errors;
    int              checks;

    `include "exec_ref.svh"

    exec_unit dut (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .resp         (resp)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] enc_reg(input logic [5:0] op, input logic [4:0] rt,
                                            input logic [4:0] ra, input logic [4:0] rb,
                                            input logic [4:0] sub);
        return {1'b0, op, rt, ra, rb, 5'd0, sub};
    endfunction

    function automatic logic [31:0] enc_imm(input logic [5:0] op, input logic [4:0] rt,
                                            input logic [4:0] ra, input logic [14:0] imm);
        return {1'b0, op, rt, ra, imm};
    endfunction

    function automatic logic [31:0] enc_ls(input logic [4:0] rt, input logic [4:0] ra,
                                           input logic [4:0] rb, input logic [7:0] lsub);
        return {1'b0, OP_TY_LS, rt, ra, rb, 2'b00, lsub};
    endfunction

    // drive one word and record what it should produce
    task automatic issue(input logic [31:0] word);
        logic [31:0] s1;
        logic [31:0] s2;
        logic        wr;
        logic [32:0] ovf_res;
        alu_resp_t   exp_resp;
        @(posedge clk);
        #0.5;
        instr       = word;
        instr_valid = 1'b1;
        ref_operands(word, shadow[word[19:15]], shadow[word[14:10]], s1, s2, wr);
        ovf_res           = ref_alu(word, s1, s2);
        exp_resp.result   = ovf_res[31:0];
        exp_resp.overflow = ovf_res[32];
        exp_resp.zero     = (ovf_res[31:0] == '0);
        expected_q.push_back(exp_resp);
        if (wr)
        begin
            shadow[word[24:20]] = ovf_res[31:0];
        end
    endtask

    // movi upper bits, shift, then or in the low 12
    task automatic load_reg(input logic [4:0] r, input logic [31:0] v);
        issue(enc_imm(OP_MOVI, r, v[31:27], v[26:12]));
        issue(enc_reg(OP_TY_BASE, r, r, 5'd12, SUB_SLLI));
        issue(enc_imm(OP_ORI, r, r, {3'b000, v[11:0]}));
    endtask

    task automatic read_reg(input logic [4:0] r);
        issue(enc_reg(OP_TY_BASE, 5'd31, r, r, SUB_OR));
    endtask

    // strobe seen at the last edge
    always @(posedge clk)
    begin
        strobe_d <= instr_valid && !reset;
    end

    always @(negedge clk)
    begin
        if (!reset && (result_valid !== strobe_d))
        begin
            $display("CHECK FAILED %0t result_valid expected %b actual %b",
                     $time, strobe_d, result_valid);
            errors++;
        end
        if (!reset && result_valid)
        begin
            if (expected_q.size() == 0)
            begin
                $display("%0t: result_valid high with no result expected", $time);
                errors++;
            end
            else
            begin
                want = expected_q.pop_front();
                checks++;
                if (resp.result !== want.result)
                begin
                    $display("CHECK FAILED %0t resp.result expected %h actual %h",
                             $time, want.result, resp.result);
                    errors++;
                end
                if (resp.overflow !== want.overflow)
                begin
                    $display("CHECK FAILED %0t resp.overflow expected %b actual %b",
                             $time, want.overflow, resp.overflow);
                    errors++;
                end
                if (resp.zero !== want.zero)
                begin
                    $display("CHECK FAILED %0t resp.zero expected %b actual %b",
                             $time, want.zero, resp.zero);
                    errors++;
                end
            end
        end
    end

    initial
    begin
        seed        = 32'h34d1;
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        errors      = 0;
        checks      = 0;
        for (int i = 0; i < NUM_REGS; i++)
        begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge clk);
        #0.5;
        reset = 1'b0;

        // quiet after reset
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clk);
            if (resp !== '0)
            begin
                $display("CHECK FAILED %0t resp expected %h actual %h", $time, 34'h0, resp);
                errors++;
            end
        end

        // movi chain and read back
        for (int i = 1; i < 9; i++)
        begin
            rnd = $random(seed);
            issue(enc_imm(OP_MOVI, i[4:0], rnd[19:15], rnd[14:0]));
        end
        for (int i = 1; i < 9; i++)
        begin
            read_reg(i[4:0]);
        end

        // add, sub, addi with edge values first
        load_reg(5'd1, 32'h7fffffff);
        load_reg(5'd2, 32'h00000001);
        issue(enc_reg(OP_TY_BASE, 5'd3, 5'd1, 5'd2, SUB_ADD));
        issue(enc_imm(OP_ADDI, 5'd4, 5'd1, 15'h0001));
        load_reg(5'd1, 32'h80000000);
        issue(enc_reg(OP_TY_BASE, 5'd3, 5'd1, 5'd2, SUB_SUB));
        issue(enc_imm(OP_ADDI, 5'd4, 5'd1, 15'h7fff));
        for (int i = 0; i < 20; i++)
        begin
            load_reg(5'd1, $random(seed));
            load_reg(5'd2, $random(seed));
            issue(enc_reg(OP_TY_BASE, 5'd3, 5'd1, 5'd2, SUB_ADD));
            issue(enc_reg(OP_TY_BASE, 5'd4, 5'd1, 5'd2, SUB_SUB));
            rnd = $random(seed);
            issue(enc_imm(OP_ADDI, 5'd5, 5'd1, rnd[14:0]));
            issue(enc_reg(OP_TY_BASE, 5'd6, 5'd1, 5'd2, SUB_AND));
            issue(enc_reg(OP_TY_BASE, 5'd6, 5'd1, 5'd2, SUB_OR));
            issue(enc_reg(OP_TY_BASE, 5'd6, 5'd1, 5'd2, SUB_XOR));
            rnd = $random(seed);
            issue(enc_imm(OP_ORI, 5'd7, 5'd1, rnd[14:0]));
            rnd = $random(seed);
            issue(enc_imm(OP_XORI, 5'd7, 5'd2, rnd[14:0]));
        end

        // zero flag cases
        load_reg(5'd7, 32'h0);
        issue(enc_reg(OP_TY_BASE, 5'd8, 5'd1, 5'd1, SUB_XOR));
        issue(enc_reg(OP_TY_BASE, 5'd8, 5'd1, 5'd7, SUB_AND));
        issue(enc_imm(OP_XORI, 5'd8, 5'd7, 15'h0000));

        // every shift amount
        load_reg(5'd1, $random(seed));
        for (int n = 0; n < 32; n++)
        begin
            issue(enc_reg(OP_TY_BASE, 5'd2, 5'd1, n[4:0], SUB_SLLI));
            issue(enc_reg(OP_TY_BASE, 5'd3, 5'd1, n[4:0], SUB_SRLI));
            issue(enc_reg(OP_TY_BASE, 5'd4, 5'd1, n[4:0], SUB_ROTRI));
        end

        // address and compare ops leave their targets alone
        for (int i = 10; i < 17; i++)
        begin
            load_reg(i[4:0], $random(seed));
        end
        issue(enc_imm(OP_LWI, 5'd12, 5'd10, 15'h0123));
        issue(enc_imm(OP_SWI, 5'd13, 5'd10, 15'h7ff0));
        issue(enc_ls(5'd14, 5'd10, 5'd11, LS_LW));
        issue(enc_ls(5'd15, 5'd10, 5'd11, LS_SW));
        issue(enc_imm(OP_TY_B, 5'd16, 5'd10, {5'd11, 10'd0}));
        issue(enc_imm(OP_TY_B, 5'd16, 5'd10, {5'd10, 10'd0}));

        // jj and undefined encodings
        rnd = $random(seed);
        issue(enc_imm(OP_JJ, 5'd12, 5'd10, rnd[14:0]));
        rnd = $random(seed);
        issue(enc_imm(6'b111111, 5'd13, 5'd10, rnd[14:0]));
        issue(enc_reg(OP_TY_BASE, 5'd14, 5'd10, 5'd11, 5'b11111));
        issue(enc_ls(5'd15, 5'd10, 5'd11, 8'h55));
        for (int i = 12; i < 17; i++)
        begin
            read_reg(i[4:0]);
        end

        // dependent chain on every cycle
        for (int i = 0; i < 10; i++)
        begin
            issue(enc_imm(OP_ADDI, 5'd20, 5'd20, 15'h0003));
            issue(enc_reg(OP_TY_BASE, 5'd21, 5'd21, 5'd20, SUB_ADD));
        end

        @(posedge clk);
        #0.5;
        instr_valid = 1'b0;
        for (int i = 0; i < 50 && expected_q.size() > 0; i++)
        begin
            @(negedge clk);
        end
        if (expected_q.size() != 0)
        begin
            $display("timeout: %0d expected results never came", expected_q.size());
            errors++;
        end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+verif
rtl/exec_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/exec_unit.sv
verif/tb_exec_unit.sv

//--- Bender.yml
package:
  name: exec_unit

sources:
  - rtl/exec_pkg.sv
  - rtl/instr_decoder.sv
  - rtl/reg_file.sv
  - rtl/alu.sv
  - rtl/exec_unit.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_exec_unit.sv
